// File: design/flash_rd_pkg.sv
//----------------------------------------------------------------------
// Flash read controller types.
// Command opcodes, status codes and the sequencer state encoding.
//----------------------------------------------------------------------
`default_nettype none

package flash_rd_pkg;

   // Opcodes of the serial NOR flash that the controller issues.
   typedef enum logic [7:0] {
      CMD_RESUME_DPD = 8'hAB,
      CMD_FAST_READ  = 8'h0B,
      CMD_DPD        = 8'hB9
   } flash_cmd_e;

   // Status reported to the application.
   typedef enum logic [3:0] {
      STATUS_OK  = 4'h0,
      STATUS_END = 4'hF
   } status_e;

   // Read sequencer states.
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_RESUME,
      ST_RESUME_WAIT,
      ST_RD_CMD,
      ST_RD_DATA,
      ST_DPD,
      ST_END
   } rd_state_e;

endpackage

`default_nettype wire

// File: design/flash_rd_top.sv
//----------------------------------------------------------------------
// Serial NOR flash read controller, top level.
// Connects the application ports to the read sequencer and the SPI
// pins to the byte shifter.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "flash_rd_params.svh"

module flash_rd_top (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  logic                     in_en_i,
   input  logic                     in_ready_i,
   input  logic                     clear_status_i,
   input  logic                     miso_i,
   input  logic [`BLOCK_ADDR_W-1:0] start_block_addr_i,
   input  logic [`BLOCK_ADDR_W-1:0] end_block_addr_i,
   input  logic [`BLOCK_OFS_W-1:0]  read_addr_offset_i,
   output logic [7:0]               in_data_o,
   output logic                     in_valid_o,
   output flash_rd_pkg::status_e    status_o,
   output logic                     sck_o,
   output logic                     csn_o,
   output logic                     mosi_o
);

   spi_byte_if spi_bus ();

   flash_read_ctrl u_ctrl (
      .clk_i              (clk_i),
      .rstn_i             (rstn_i),
      .in_en_i            (in_en_i),
      .in_ready_i         (in_ready_i),
      .clear_status_i     (clear_status_i),
      .start_block_addr_i (start_block_addr_i),
      .end_block_addr_i   (end_block_addr_i),
      .read_addr_offset_i (read_addr_offset_i),
      .in_data_o          (in_data_o),
      .in_valid_o         (in_valid_o),
      .status_o           (status_o),
      .spi_bus            (spi_bus.ctrl)
   );

   spi_byte_engine u_engine (
      .clk_i   (clk_i),
      .rstn_i  (rstn_i),
      .miso_i  (miso_i),
      .spi_bus (spi_bus.engine),
      .sck_o   (sck_o),
      .csn_o   (csn_o),
      .mosi_o  (mosi_o)
   );

endmodule

`default_nettype wire

// File: design/flash_read_ctrl.sv
//----------------------------------------------------------------------
// Flash read sequencer.
// Wakes the flash from deep power-down, issues a fast read at the
// requested block and offset, streams bytes to the application up to
// the end of the last block, then powers the flash down again and
// reports end of operation until it is cleared.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "flash_rd_params.svh"

module flash_read_ctrl (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  logic                     in_en_i,
   input  logic                     in_ready_i,
   input  logic                     clear_status_i,
   input  logic [`BLOCK_ADDR_W-1:0] start_block_addr_i,
   input  logic [`BLOCK_ADDR_W-1:0] end_block_addr_i,
   input  logic [`BLOCK_OFS_W-1:0]  read_addr_offset_i,
   output logic [7:0]               in_data_o,
   output logic                     in_valid_o,
   output flash_rd_pkg::status_e    status_o,
   spi_byte_if.ctrl                 spi_bus
);
   import flash_rd_pkg::*;

   localparam int STEP_W = 3;
   localparam int CMD_ADDR_W = 8 * `CMD_ADDR_BYTES;
   localparam logic [STEP_W-1:0] STEP_DUMMY = STEP_W'(`CMD_ADDR_BYTES + 1);
   localparam logic [STEP_W-1:0] STEP_DONE = STEP_W'(`CMD_ADDR_BYTES + 2);

   rd_state_e                state_q, state_d;
   logic [STEP_W-1:0]        step_q, step_d;
   logic [15:0]              wait_cnt_q, wait_cnt_d;
   logic                     in_en_q;
   logic                     req_q, req_d;
   logic                     streamed_q, streamed_d;
   logic                     inflight_q, inflight_d;
   logic [`FLASH_ADDR_W-1:0] addr_q, addr_d;
   logic [`BLOCK_ADDR_W-1:0] end_blk_q;
   logic [CMD_ADDR_W-1:0]    cmd_addr;
   logic                     in_en_rise;
   logic                     live;
   logic                     last_byte;
   logic                     rd_go;

   assign in_en_rise = in_en_i && !in_en_q;
   // The request stays live until in_en_i drops or the last byte arrives.
   assign live = req_q && in_en_i;
   assign last_byte = (addr_q == {end_blk_q, {`BLOCK_OFS_W{1'b1}}});
   assign cmd_addr = CMD_ADDR_W'(addr_q);
   assign rd_go = (state_q == ST_RD_DATA) && live && in_ready_i && !inflight_q;

   always_comb begin
      state_d = state_q;
      step_d = step_q;
      wait_cnt_d = wait_cnt_q;
      req_d = live;
      streamed_d = streamed_q;
      inflight_d = inflight_q;
      addr_d = addr_q;
      spi_bus.en = 1'b0;
      spi_bus.wr_data = 8'h00;
      spi_bus.wr_valid = 1'b0;
      spi_bus.rd_ready = rd_go;
      in_valid_o = 1'b0;
      case (state_q)
         ST_IDLE: begin
            streamed_d = 1'b0;
            step_d = '0;
            if (in_en_rise) begin
               req_d = 1'b1;
               addr_d = {start_block_addr_i, read_addr_offset_i};
               state_d = ST_RESUME;
            end
         end
         ST_RESUME: begin
            spi_bus.en = 1'b1;
            if (step_q == '0) begin
               spi_bus.wr_data = CMD_RESUME_DPD;
               spi_bus.wr_valid = 1'b1;
               if (spi_bus.wr_ready) begin
                  step_d = STEP_W'(1);
               end
            end else if (spi_bus.rd_valid) begin
               state_d = ST_RESUME_WAIT;
               step_d = '0;
               wait_cnt_d = 16'd0;
            end
         end
         ST_RESUME_WAIT: begin
            wait_cnt_d = wait_cnt_q + 16'd1;
            if (wait_cnt_q == 16'(`RESUME_CYCLES - 1)) begin
               state_d = live ? ST_RD_CMD : ST_DPD;
            end
         end
         ST_RD_CMD: begin
            spi_bus.en = 1'b1;
            if (step_q == STEP_DONE) begin
               // The dummy byte has completed, data follows from here on.
               if (spi_bus.rd_valid) begin
                  step_d = '0;
                  inflight_d = 1'b0;
                  streamed_d = live;
                  state_d = live ? ST_RD_DATA : ST_DPD;
               end
            end else begin
               spi_bus.wr_valid = 1'b1;
               if (step_q == '0) begin
                  spi_bus.wr_data = CMD_FAST_READ;
               end else if (step_q < STEP_DUMMY) begin
                  spi_bus.wr_data = 8'(cmd_addr >> (8 * (`CMD_ADDR_BYTES - int'(step_q))));
               end
               if (spi_bus.wr_ready) begin
                  step_d = step_q + STEP_W'(1);
               end
            end
         end
         ST_RD_DATA: begin
            spi_bus.en = 1'b1;
            in_valid_o = spi_bus.rd_valid;
            if (rd_go) begin
               inflight_d = 1'b1;
            end else if (spi_bus.rd_valid) begin
               inflight_d = 1'b0;
               addr_d = addr_q + 1'b1;
               if (last_byte) begin
                  req_d = 1'b0;
               end
            end
            // A byte in flight is delivered before the frame closes.
            if (!live && !inflight_q) begin
               state_d = ST_DPD;
               step_d = '0;
            end
         end
         ST_DPD: begin
            if (step_q == '0) begin
               // One cycle with en low so power-down gets its own frame.
               step_d = STEP_W'(1);
            end else if (step_q == STEP_W'(1)) begin
               spi_bus.en = 1'b1;
               spi_bus.wr_data = CMD_DPD;
               spi_bus.wr_valid = 1'b1;
               if (spi_bus.wr_ready) begin
                  step_d = STEP_W'(2);
               end
            end else begin
               spi_bus.en = 1'b1;
               if (spi_bus.rd_valid) begin
                  step_d = '0;
                  state_d = streamed_q ? ST_END : ST_IDLE;
               end
            end
         end
         ST_END: begin
            if (clear_status_i) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q <= ST_IDLE;
         step_q <= '0;
         wait_cnt_q <= 16'd0;
         in_en_q <= 1'b0;
         req_q <= 1'b0;
         streamed_q <= 1'b0;
         inflight_q <= 1'b0;
      end else begin
         state_q <= state_d;
         step_q <= step_d;
         wait_cnt_q <= wait_cnt_d;
         in_en_q <= in_en_i;
         req_q <= req_d;
         streamed_q <= streamed_d;
         inflight_q <= inflight_d;
      end
   end

   // Address counter and end block of the current request.
   always_ff @(posedge clk_i) begin
      addr_q <= addr_d;
      if (state_q == ST_IDLE && in_en_rise) begin
         end_blk_q <= end_block_addr_i;
      end
   end

   assign in_data_o = spi_bus.rd_data;
   assign status_o = (state_q == ST_END) ? STATUS_END : STATUS_OK;

   // The shifter stays quiet and no data leaves while no read is running.
   a_no_data_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
      (state_q == ST_IDLE || state_q == ST_END) |-> !in_valid_o && !spi_bus.rd_valid);

endmodule

`default_nettype wire

// File: design/spi_byte_engine.sv
//----------------------------------------------------------------------
// SPI byte shifter.
// Mode-0 master that drives SCK, chip select and MOSI MSB first and
// samples MISO on the rising SCK edge. One byte lasts 16 SCK
// half-periods of SCK_DIV clock cycles each.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "flash_rd_params.svh"

module spi_byte_engine (
   input  logic       clk_i,
   input  logic       rstn_i,
   input  logic       miso_i,
   spi_byte_if.engine spi_bus,
   output logic       sck_o,
   output logic       csn_o,
   output logic       mosi_o
);

   localparam int DIV_W = $clog2(`SCK_DIV + 1);

   logic [DIV_W-1:0] div_q;
   logic [3:0]       half_q;
   logic             busy_q;
   logic             csn_q;
   logic             sck_q;
   logic             mosi_q;
   logic             wr_ready_q;
   logic             rd_valid_q;
   logic [7:0]       tx_q;
   logic [7:0]       rx_q;
   logic             start;
   logic             edge_tick;

   // A byte starts only inside an open frame with the shifter idle.
   assign start = spi_bus.en && !csn_q && !busy_q && (spi_bus.wr_valid || spi_bus.rd_ready);
   assign edge_tick = busy_q && (div_q == DIV_W'(`SCK_DIV - 1));

   // Chip select follows en but is held low until the current byte ends.
   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         csn_q <= 1'b1;
      end else if (spi_bus.en) begin
         csn_q <= 1'b0;
      end else if (!busy_q) begin
         csn_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         busy_q     <= 1'b0;
         div_q      <= '0;
         half_q     <= 4'd0;
         sck_q      <= 1'b0;
         mosi_q     <= 1'b0;
         wr_ready_q <= 1'b0;
         rd_valid_q <= 1'b0;
      end else begin
         wr_ready_q <= start && spi_bus.wr_valid;
         rd_valid_q <= 1'b0;
         if (start) begin
            busy_q <= 1'b1;
            div_q  <= '0;
            half_q <= 4'd0;
            // Read bytes shift out zeros.
            mosi_q <= spi_bus.wr_valid ? spi_bus.wr_data[7] : 1'b0;
         end else if (edge_tick) begin
            div_q  <= '0;
            sck_q  <= !sck_q;
            half_q <= half_q + 4'd1;
            if (sck_q) begin
               if (half_q == 4'd15) begin
                  busy_q     <= 1'b0;
                  rd_valid_q <= 1'b1;
                  mosi_q     <= 1'b0;
               end else begin
                  mosi_q <= tx_q[6];
               end
            end
         end else if (busy_q) begin
            div_q <= div_q + DIV_W'(1);
         end
      end
   end

   // Shift registers for the outgoing and incoming byte.
   always_ff @(posedge clk_i) begin
      if (start) begin
         tx_q <= spi_bus.wr_valid ? spi_bus.wr_data : 8'h00;
      end else if (edge_tick && sck_q) begin
         tx_q <= {tx_q[6:0], 1'b0};
      end
      if (edge_tick && !sck_q) begin
         rx_q <= {rx_q[6:0], miso_i};
      end
   end

   assign spi_bus.wr_ready = wr_ready_q;
   assign spi_bus.rd_valid = rd_valid_q;
   assign spi_bus.rd_data  = rx_q;
   assign sck_o  = sck_q;
   assign csn_o  = csn_q;
   assign mosi_o = mosi_q;

   // The wr_ready pulse falls in the first cycle of a byte, before SCK has moved.
   a_wr_ready_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
      spi_bus.wr_ready |-> (half_q == 4'd0 && div_q == '0 && !sck_q));

   // SCK is parked low outside a chip-select frame.
   a_sck_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
      csn_o |-> !sck_o);

endmodule

`default_nettype wire

// File: design/spi_byte_if.sv
//----------------------------------------------------------------------
// SPI byte interface.
// Byte traffic between the read sequencer and the SPI shifter.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if;

   logic       en;
   logic [7:0] wr_data;
   logic       wr_valid;
   logic       wr_ready;
   logic       rd_ready;
   logic [7:0] rd_data;
   logic       rd_valid;

   // The sequencer side opens the frame and requests bytes.
   modport ctrl (
      output en, wr_data, wr_valid, rd_ready,
      input  wr_ready, rd_data, rd_valid
   );

   // The shifter side accepts bytes and returns what it received.
   modport engine (
      input  en, wr_data, wr_valid, rd_ready,
      output wr_ready, rd_data, rd_valid
   );

endinterface

`default_nettype wire

// File: flash_rd.f
+incdir+include
design/flash_rd_pkg.sv
design/spi_byte_if.sv
design/spi_byte_engine.sv
design/flash_read_ctrl.sv
design/flash_rd_top.sv
sim/tb_clk_gen.sv
sim/flash_model.sv
sim/tb_flash_rd.sv

// File: include/flash_rd_params.svh
//----------------------------------------------------------------------
// Flash read controller parameters.
// Flash geometry, clock rates, SCK divider and deep power-down resume
// time shared by the controller, the SPI shifter and the flash model.
//----------------------------------------------------------------------
`ifndef FLASH_RD_PARAMS_SVH
`define FLASH_RD_PARAMS_SVH

// Flash geometry in bytes and address bits.
`define FLASH_SIZE         1048576
`define FLASH_ADDR_W       20
`define BLOCK_SIZE         4096
`define BLOCK_OFS_W        12
`define BLOCK_ADDR_W       (`FLASH_ADDR_W - `BLOCK_OFS_W)

// System clock rate and deep power-down resume time.
`define CLK_PERIODS_PER_US 10
`define RESUME_US          10
`define RESUME_CYCLES      (((`RESUME_US * `CLK_PERIODS_PER_US) > 65535) ? 65535 : \
                            (`RESUME_US * `CLK_PERIODS_PER_US))

// Number of clk_i cycles in one SCK half-period.
`define SCK_DIV            2

// Address bytes sent after a command opcode.
`define CMD_ADDR_BYTES     3

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the flash read testbench with Verilator.

verilator --binary --timing --assert -Wno-fatal -f flash_rd.f \
   --top-module tb_flash_rd -o sim_flash_rd > build.log 2>&1 \
   || { cat build.log; echo "Verilator build error"; exit 1; }

./obj_dir/sim_flash_rd > sim.log 2>&1
cat sim.log

grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// File: sim/flash_model.sv
//----------------------------------------------------------------------
// Behavioral SPI NOR flash.
// Decodes mode-0 commands on the bus pins, answers fast reads with
// address-derived data and logs opcode, address and length per frame.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "flash_rd_params.svh"

module flash_model (
   input  logic sck_i,
   input  logic csn_i,
   input  logic mosi_i,
   output logic miso_o
);
   import flash_rd_pkg::*;

   localparam int MAX_FRAMES = 32;
   // Data starts after the opcode, the address bytes and one dummy byte.
   localparam int DATA_START = `CMD_ADDR_BYTES + 2;

   logic [7:0]  frame_op [MAX_FRAMES];
   logic [23:0] frame_addr [MAX_FRAMES];
   int          frame_len [MAX_FRAMES];
   int          frame_cnt;
   logic [7:0]  rx_byte;
   logic [7:0]  tx_byte;
   logic [7:0]  op;
   logic [23:0] addr;
   int          bit_cnt;
   int          byte_cnt;

   function automatic logic [7:0] read_byte(input logic [23:0] a);
      return a[7:0] ^ a[15:8];
   endfunction

   initial begin
      frame_cnt = 0;
      byte_cnt = 0;
      bit_cnt = 0;
      miso_o = 1'b0;
   end

   // A falling chip select starts a new frame; rising SCK samples MOSI.
   always @(posedge sck_i or negedge csn_i) begin
      if (!sck_i) begin
         bit_cnt = 0;
         byte_cnt = 0;
         op = 8'h00;
         addr = 24'h0;
      end else if (!csn_i) begin
         rx_byte = {rx_byte[6:0], mosi_i};
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 8) begin
            bit_cnt = 0;
            if (byte_cnt == 0) begin
               op = rx_byte;
            end else if (byte_cnt <= `CMD_ADDR_BYTES) begin
               addr = {addr[15:0], rx_byte};
            end
            byte_cnt = byte_cnt + 1;
         end
      end
   end

   // Read data changes on the falling SCK edge, MSB first.
   always @(negedge sck_i) begin
      if (!csn_i && op == CMD_FAST_READ && byte_cnt >= DATA_START) begin
         if (bit_cnt == 0) begin
            tx_byte = read_byte(addr + 24'(byte_cnt - DATA_START));
         end else begin
            tx_byte = {tx_byte[6:0], 1'b0};
         end
         miso_o = tx_byte[7];
      end
   end

   always @(posedge csn_i) begin
      if (byte_cnt > 0 && frame_cnt < MAX_FRAMES) begin
         frame_op[frame_cnt] = op;
         frame_addr[frame_cnt] = addr;
         frame_len[frame_cnt] = byte_cnt;
         frame_cnt = frame_cnt + 1;
      end
   end

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
//----------------------------------------------------------------------
// Testbench clock and reset.
// Free-running 4 ns clock and an active-low reset held for two cycles.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int HALF_PERIOD_NS = 2,
   parameter int RESET_CYCLES   = 2
) (
   output logic clk_o,
   output logic rstn_o
);

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   // Release reset just after a rising edge.
   initial begin
      rstn_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      rstn_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: sim/tb_flash_rd.sv
//----------------------------------------------------------------------
// Flash read controller testbench.
// Runs a table of block reads against a behavioral flash, checks the
// data stream, the chip-select frames and the end status.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "flash_rd_params.svh"

module tb_flash_rd;
   import flash_rd_pkg::*;

   localparam int NUM_ROWS = 4;
   localparam int HOLD_CYCLES = 6;
   localparam int MARGIN_CYCLES = 2000;

   // Columns are start block, end block, byte offset and the byte count after
   // which in_en_i drops, where 0 reads through the end block.
   localparam int ROW_START [NUM_ROWS] = '{0, 3, 7, 5};
   localparam int ROW_END [NUM_ROWS] = '{0, 3, 8, 6};
   localparam int ROW_OFS [NUM_ROWS] = '{0, 1000, 3500, 100};
   localparam int ROW_ABORT [NUM_ROWS] = '{0, 0, 0, 20};

   logic                     clk;
   logic                     rstn;
   logic                     in_en;
   logic                     in_ready;
   logic                     clear_status;
   logic                     miso;
   logic [`BLOCK_ADDR_W-1:0] start_blk;
   logic [`BLOCK_ADDR_W-1:0] end_blk;
   logic [`BLOCK_OFS_W-1:0]  ofs;
   logic [7:0]               in_data;
   logic                     in_valid;
   status_e                  status;
   logic                     sck;
   logic                     csn;
   logic                     mosi;
   integer                   seed;
   int                       errors;

   tb_clk_gen clk_gen_i (
      .clk_o  (clk),
      .rstn_o (rstn)
   );

   flash_model flash_i (
      .sck_i  (sck),
      .csn_i  (csn),
      .mosi_i (mosi),
      .miso_o (miso)
   );

   flash_rd_top dut_i (
      .clk_i              (clk),
      .rstn_i             (rstn),
      .in_en_i            (in_en),
      .in_ready_i         (in_ready),
      .clear_status_i     (clear_status),
      .miso_i             (miso),
      .start_block_addr_i (start_blk),
      .end_block_addr_i   (end_blk),
      .read_addr_offset_i (ofs),
      .in_data_o          (in_data),
      .in_valid_o         (in_valid),
      .status_o           (status),
      .sck_o              (sck),
      .csn_o              (csn),
      .mosi_o             (mosi)
   );

   // Flash content rule: low address byte XOR middle address byte.
   function automatic logic [7:0] expected_byte(input logic [19:0] a);
      return a[7:0] ^ a[15:8];
   endfunction

   function automatic longint watchdog_cycles();
      longint bytes;
      bytes = 0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         bytes += longint'((ROW_END[r] - ROW_START[r] + 1) * `BLOCK_SIZE - ROW_OFS[r]);
      end
      return bytes * 40 * `SCK_DIV + NUM_ROWS * (`RESUME_CYCLES + MARGIN_CYCLES)
         + MARGIN_CYCLES;
   endfunction

   task automatic report_mismatch(input string name, input longint got, input longint exp);
      $display("[ERROR] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors++;
   endtask

   // Outputs are sampled and inputs driven 1 ns after the rising edge.
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_frames(input int base, input logic [23:0] rd_addr,
                               input int data_len);
      assert (flash_i.frame_cnt == base + 3)
         else report_mismatch("flash frame count", flash_i.frame_cnt, base + 3);
      if (flash_i.frame_cnt == base + 3) begin
         assert (flash_i.frame_op[base] == CMD_RESUME_DPD)
            else report_mismatch("resume opcode", flash_i.frame_op[base], CMD_RESUME_DPD);
         assert (flash_i.frame_len[base] == 1)
            else report_mismatch("resume frame length", flash_i.frame_len[base], 1);
         assert (flash_i.frame_op[base+1] == CMD_FAST_READ)
            else report_mismatch("read opcode", flash_i.frame_op[base+1], CMD_FAST_READ);
         assert (flash_i.frame_addr[base+1] == rd_addr)
            else report_mismatch("read address", flash_i.frame_addr[base+1], rd_addr);
         // Opcode, address bytes and one dummy byte precede the data bytes.
         assert (flash_i.frame_len[base+1] == `CMD_ADDR_BYTES + 2 + data_len)
            else report_mismatch("fast-read frame length", flash_i.frame_len[base+1],
               `CMD_ADDR_BYTES + 2 + data_len);
         assert (flash_i.frame_op[base+2] == CMD_DPD)
            else report_mismatch("power-down opcode", flash_i.frame_op[base+2], CMD_DPD);
         assert (flash_i.frame_len[base+2] == 1)
            else report_mismatch("power-down frame length", flash_i.frame_len[base+2], 1);
      end
   endtask

   task automatic run_row(input int row);
      int         sb;
      int         eb;
      int         ob;
      int         count;
      int         expect_len;
      int         base;
      logic [19:0] first;
      logic [19:0] addr;
      sb = ROW_START[row];
      eb = ROW_END[row];
      ob = ROW_OFS[row];
      start_blk = sb[`BLOCK_ADDR_W-1:0];
      end_blk = eb[`BLOCK_ADDR_W-1:0];
      ofs = ob[`BLOCK_OFS_W-1:0];
      first = {start_blk, ofs};
      addr = first;
      expect_len = (eb - sb + 1) * `BLOCK_SIZE - ob;
      count = 0;
      base = flash_i.frame_cnt;
      in_en = 1'b1;
      while (status != STATUS_END) begin
         next_cycle();
         if (in_valid) begin
            assert (in_data == expected_byte(addr))
               else report_mismatch("in_data_o", in_data, expected_byte(addr));
            addr = addr + 20'd1;
            count++;
            if (count == ROW_ABORT[row]) begin
               in_en = 1'b0;
            end
         end
         in_ready = ($random(seed) & 1) != 0;
      end
      in_en = 1'b0;
      if (ROW_ABORT[row] == 0) begin
         assert (count == expect_len)
            else report_mismatch("in_valid_o pulse count", count, expect_len);
      end else begin
         assert (count >= ROW_ABORT[row] && count <= ROW_ABORT[row] + 1) else begin
            $display("Aborted read in row %0d delivered %0d bytes after a drop at %0d",
               row, count, ROW_ABORT[row]);
            errors++;
         end
      end
      // The end status must hold until it is cleared.
      repeat (HOLD_CYCLES) begin
         next_cycle();
         assert (status == STATUS_END) else report_mismatch("status_o", status, STATUS_END);
      end
      check_frames(base, {4'h0, first}, count);
      clear_status = 1'b1;
      next_cycle();
      clear_status = 1'b0;
      assert (status == STATUS_OK) else report_mismatch("status_o", status, STATUS_OK);
   endtask

   initial begin : main
      seed = 32'h8f9493db;
      errors = 0;
      in_en = 1'b0;
      in_ready = 1'b0;
      clear_status = 1'b0;
      start_blk = '0;
      end_blk = '0;
      ofs = '0;
      wait (rstn === 1'b1);
      next_cycle();
      assert (status == STATUS_OK) else report_mismatch("status_o", status, STATUS_OK);
      assert (csn === 1'b1) else report_mismatch("csn_o", csn, 1);
      assert (in_valid === 1'b0) else report_mismatch("in_valid_o", in_valid, 0);
      for (int row = 0; row < NUM_ROWS; row++) begin
         run_row(row);
      end
      $display("Summary: %0d errors over %0d table rows", errors, NUM_ROWS);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin : watchdog
      longint limit;
      limit = watchdog_cycles();
      repeat (limit) @(posedge clk);
      $display("Timeout: the reads did not finish within %0d clock cycles", limit);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire
